//--- core_patterns.txt
// op a b expected, all hex
// op 0 add, 1 sub, 2 mov, 3 ftoi
0 00000005 00000003 00000008
0 ffffffff 00000001 00000000
0 7fffffff 00000001 80000000
1 00000003 00000005 fffffffe
1 12345678 02345678 10000000
2 deadbeef 01234567 deadbeef
3 3f800000 00000000 00000001
3 40490fdb 00000000 00000003
3 c0490fdb 00000000 fffffffd
3 3f000000 00000000 00000000
3 00000000 00000000 00000000
3 4f000000 00000000 7fffffff
3 cf000000 00000000 80000000
3 7fc00000 00000000 7fffffff
3 ff800000 00000000 80000000
3 c2f6e979 00000000 ffffff85
3 41200000 00000000 0000000a
0 00000010 00000020 00000030
3 c1a80000 00000000 ffffffeb
1 00000100 00000001 000000ff
3 4effffff 00000000 7fffff80
3 3fffffff 00000000 00000001
2 00c0ffee 00000000 00c0ffee
0 80000000 80000000 00000000
0 00000001 00000001 00000002
0 00000002 00000002 00000004
3 4b800001 00000000 01000002
1 00000010 00000001 0000000f
2 a5a5a5a5 00000000 a5a5a5a5
3 42c80000 00000000 00000064
0 11111111 22222222 33333333
1 00000000 00000010 fffffff0
2 5a5a5a5a 00000000 5a5a5a5a
3 bf800000 00000000 ffffffff

//--- list.f
+incdir+.
core_pkg.sv
cdb_issue.sv
int_alu.sv
ftoi_unit.sv
commit_ring.sv
byte_sender.sv
ooo_core_top.sv
tb_core_asserts.sv
tb_core.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f list.f -o sim_core \
	&& ./obj_dir/sim_core +verilator+error+limit+100 | tee /dev/stderr \
	| grep -q "TEST RESULT: PASS" \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }

//--- tb_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module tb_core;
	import core_pkg::*;

	localparam int N_PAT = 34;
	localparam int WATCHDOG_CYCLES = 40 * N_PAT + 200;
	localparam int MODE_HIGH = 0;
	localparam int MODE_LOW = 1;
	localparam int MODE_RAND = 2;

	logic       clk;
	logic       rst_n;
	inst_t      inst;
	logic       inst_valid;
	logic       tx_ready;
	logic       inst_ready;
	logic [7:0] tx_data;
	logic       tx_valid;

	// four entries per pattern: op, a, b, expected word
	logic [`WORD_W-1:0] pat [0:4*N_PAT-1];

	int seed = 32'h85cf_5f58;
	int gap_seed;
	int tx_mode = MODE_HIGH;
	int words_seen = 0;
	int errors = 0;
	int tests_pass = 0;
	int tests_fail = 0;

	ooo_core_top UUT (
		.clk,
		.rst_n,
		.inst,
		.inst_valid,
		.tx_ready,
		.inst_ready,
		.tx_data,
		.tx_valid
	);

	bind ooo_core_top tb_core_asserts u_asserts (
		.clk,
		.rst_n,
		.alu_issue,
		.ftoi_issue,
		.tx_ready,
		.tx_data,
		.tx_valid
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////
	// compare and bookkeeping
	////////////////////////////////////////

	task automatic check_word(input string name, input logic [`WORD_W-1:0] exp,
			input logic [`WORD_W-1:0] got);
		if (got !== exp) begin
			$display("Fail time=%0t %s expected %h received %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic compare_byte(input string name, input logic [7:0] exp,
			input logic [7:0] got);
		if (got !== exp) begin
			$display("Fail time=%0t %s expected %h received %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic expect_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("Fail time=%0t %s expected %b received %b", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		if (errors == err_start) begin
			tests_pass++;
			$display("test %s: ok", name);
		end else begin
			tests_fail++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	task automatic wait_drained(input int n);
		while (words_seen < n) begin
			@(posedge clk);
		end
		@(negedge clk);
	endtask

	////////////////////////////////////////
	// driver
	////////////////////////////////////////

	task automatic drive_section(input int first, input int last, input bit gaps,
			input bit hold);
		logic [31:0] rnd;
		int stall;
		int taken;
		bit stalled;
		taken = 0;
		stalled = 1'b0;
		for (int i = first; i <= last; i++) begin
			if (gaps) begin
				rnd = $random(gap_seed);
				repeat (rnd[1:0]) @(negedge clk);
			end
			inst.op    = op_t'(pat[4*i][1:0]);
			inst.a     = pat[4*i+1];
			inst.b     = pat[4*i+2];
			inst_valid = 1'b1;
			stall      = 0;
			forever begin
				@(posedge clk);
				if (inst_ready) begin
					break;
				end
				stall++;
				// ring plus the word held by the sender
				if (hold && stall == 16) begin
					stalled = 1'b1;
					if (taken != `RING_DEPTH + 1) begin
						$display("ring filled after %0d words instead of %0d",
							taken, `RING_DEPTH + 1);
						errors++;
					end
					tx_mode = MODE_HIGH;
				end
			end
			taken++;
			@(negedge clk);
			inst_valid = 1'b0;
		end
		if (hold && !stalled) begin
			$display("inst_ready never dropped while tx_ready was held low");
			errors++;
		end
	endtask

	initial begin : tx_drive
		logic [31:0] rnd;
		tx_ready = 1'b1;
		forever begin
			@(negedge clk);
			case (tx_mode)
				MODE_LOW: begin
					tx_ready = 1'b0;
				end
				MODE_RAND: begin
					rnd = $random(seed);
					tx_ready = rnd[3];
				end
				default: begin
					tx_ready = 1'b1;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// monitor
	////////////////////////////////////////

	initial begin : monitor
		logic [`WORD_W-1:0] expect_word;
		logic [`WORD_W-1:0] got_word;
		int nb;
		nb = 0;
		got_word = '0;
		forever begin
			@(posedge clk);
			if (rst_n && tx_valid && tx_ready) begin
				if (words_seen >= N_PAT) begin
					$display("unexpected extra byte %h on tx_data after the last word", tx_data);
					errors++;
				end else begin
					expect_word = pat[4*words_seen+3];
					compare_byte("tx_data", expect_word[nb*8 +: 8], tx_data);
					got_word[nb*8 +: 8] = tx_data;
					if (nb == 3) begin
						check_word("tx_word", expect_word, got_word);
						words_seen++;
						nb = 0;
					end else begin
						nb++;
					end
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin : main
		int err_start;
		int asrt_fails;
		rst_n = 1'b0;
		inst = '0;
		inst_valid = 1'b0;
		$readmemh("core_patterns.txt", pat);
		gap_seed = $random(seed);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		err_start = errors;
		expect_bit("tx_valid", 1'b0, tx_valid);
		expect_bit("inst_ready", 1'b1, inst_ready);
		finish_test("reset state", err_start);

		err_start = errors;
		drive_section(0, 5, 1'b0, 1'b0);
		wait_drained(6);
		finish_test("alu results", err_start);

		// random gaps and random tx_ready
		err_start = errors;
		tx_mode = MODE_RAND;
		drive_section(6, 15, 1'b1, 1'b0);
		wait_drained(16);
		finish_test("ftoi conversions", err_start);

		err_start = errors;
		drive_section(16, 23, 1'b0, 1'b0);
		wait_drained(24);
		finish_test("mixed back to back", err_start);

		err_start = errors;
		tx_mode = MODE_LOW;
		@(negedge clk);
		drive_section(24, 33, 1'b0, 1'b1);
		wait_drained(34);
		finish_test("back-pressure", err_start);

		repeat (10) @(negedge clk);
		asrt_fails = UUT.u_asserts.fail_count;
		$display("tests passed %0d failed %0d, assertion failures %0d",
			tests_pass, tests_fail, asrt_fails);
		if (tests_fail == 0 && errors == 0 && asrt_fails == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_asserts (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       alu_issue,
	input  logic       ftoi_issue,
	input  logic       tx_ready,
	input  logic [7:0] tx_data,
	input  logic       tx_valid
);
	int fail_count = 0;

	////////////////////////////////////////
	// bus scheduling
	////////////////////////////////////////

	// an ftoi from two cycles back holds the next bus slot
	alu_slot_free: assert property (@(posedge clk) disable iff (!rst_n)
		alu_issue |-> !$past(ftoi_issue, 2))
	else begin
		fail_count++;
		$error("alu issue collides with a bus slot reserved by an ftoi");
	end

	////////////////////////////////////////
	// byte output
	////////////////////////////////////////

	tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
	else begin
		fail_count++;
		$error("tx byte changed or dropped while tx_ready was low");
	end

	tx_idle_after_reset: assert property (@(posedge clk)
		!rst_n |=> !tx_valid)
	else begin
		fail_count++;
		$error("tx_valid high in the cycle after reset");
	end

endmodule

`default_nettype wire

//--- ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module ooo_core_top (
	input  logic            clk,
	input  logic            rst_n,
	input  core_pkg::inst_t inst,
	input  logic            inst_valid,
	input  logic            tx_ready,
	output logic            inst_ready,
	output logic [7:0]      tx_data,
	output logic            tx_valid
);
	import core_pkg::*;

	logic               alloc;
	logic               alu_issue;
	logic               ftoi_issue;
	logic               ring_full;
	logic [`TAG_W-1:0]  alloc_tag;
	logic [`WORD_W-1:0] alu_result;
	logic [`WORD_W-1:0] ftoi_result;
	cdb_t               cdb;
	logic               head_valid;
	logic [`WORD_W-1:0] head_data;
	logic               take;

	////////////////////////////////////////
	// producer
	////////////////////////////////////////

	cdb_issue u_issue (
		.clk,
		.rst_n,
		.inst,
		.inst_valid,
		.ring_full,
		.alloc_tag,
		.alu_result,
		.ftoi_result,
		.inst_ready,
		.alloc,
		.alu_issue,
		.ftoi_issue,
		.cdb
	);

	int_alu u_alu (
		.clk,
		.rst_n,
		.issue(alu_issue),
		.op(inst.op),
		.a(inst.a),
		.b(inst.b),
		.result(alu_result)
	);

	ftoi_unit u_ftoi (
		.clk,
		.rst_n,
		.issue(ftoi_issue),
		.a(inst.a),
		.result(ftoi_result)
	);

	// buffer and consumer
	commit_ring u_ring (
		.clk,
		.rst_n,
		.alloc,
		.cdb,
		.take,
		.alloc_tag,
		.ring_full,
		.head_valid,
		.head_data
	);

	byte_sender u_sender (
		.clk,
		.rst_n,
		.head_valid,
		.head_data,
		.tx_ready,
		.take,
		.tx_data,
		.tx_valid
	);

endmodule

`default_nettype wire

//--- byte_sender.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module byte_sender (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               head_valid,
	input  logic [`WORD_W-1:0] head_data,
	input  logic               tx_ready,
	output logic               take,
	output logic [7:0]         tx_data,
	output logic               tx_valid
);
	logic [`WORD_W-1:0] word;
	logic [1:0]         idx;
	logic               last_out;

	// last byte leaves this cycle
	assign last_out = tx_valid && tx_ready && (idx == 2'd3);

	assign take = head_valid && (!tx_valid || last_out);

	// low byte first
	assign tx_data = word[idx*8 +: 8];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_valid <= 1'b0;
			idx      <= '0;
		end else if (take) begin
			tx_valid <= 1'b1;
			idx      <= '0;
		end else if (tx_valid && tx_ready) begin
			if (idx == 2'd3) begin
				tx_valid <= 1'b0;
			end
			idx <= idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			word <= head_data;
		end
	end

endmodule

`default_nettype wire

//--- commit_ring.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module commit_ring (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               alloc,
	input  core_pkg::cdb_t     cdb,
	input  logic               take,
	output logic [`TAG_W-1:0]  alloc_tag,
	output logic               ring_full,
	output logic               head_valid,
	output logic [`WORD_W-1:0] head_data
);
	////////////////////////////////////////
	// ring state
	////////////////////////////////////////

	logic [`TAG_W-1:0]  head;
	logic [`TAG_W-1:0]  tail;
	logic [`TAG_W:0]    count;
	logic [`RING_DEPTH-1:0] done;
	logic [`WORD_W-1:0] data [`RING_DEPTH];

	assign alloc_tag  = tail;
	assign ring_full  = count == (`TAG_W+1)'(`RING_DEPTH);
	assign head_valid = (count != '0) && done[head];
	assign head_data  = data[head];

	////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (alloc) begin
				tail <= tail + 1'b1;
			end
			if (take) begin
				head <= head + 1'b1;
			end
			case ({alloc, take})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// completion
	////////////////////////////////////////

	// a fresh entry never matches an in-flight bus tag
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done <= '0;
		end else begin
			if (alloc) begin
				done[tail] <= 1'b0;
			end
			if (cdb.valid) begin
				done[cdb.tag] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cdb.valid) begin
			data[cdb.tag] <= cdb.data;
		end
	end

endmodule

`default_nettype wire

//--- ftoi_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module ftoi_unit (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue,
	input  logic [`WORD_W-1:0] a,
	output logic [`WORD_W-1:0] result
);
	logic [7:0] exp_in;

	// stage 1 state
	logic        s1_valid;
	logic        s1_sign;
	logic        s1_zero;
	logic        s1_sat;
	logic        s1_left;
	logic [4:0]  s1_sh;
	logic [23:0] s1_mant;

	// stage 2 state
	logic               s2_valid;
	logic               s2_sign;
	logic               s2_sat;
	logic [`WORD_W-1:0] s2_mag;

	assign exp_in = a[30:23];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= issue;
			s2_valid <= s1_valid;
		end
	end

	////////////////////////////////////////
	// stage 1, unpack
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (issue) begin
			s1_sign <= a[31];
			s1_zero <= exp_in < 8'd127;
			// nan and inf land here too
			s1_sat  <= exp_in >= 8'd158;
			s1_mant <= {1'b1, a[22:0]};
			// value = mant * 2^(exp-150)
			s1_left <= exp_in >= 8'd150;
			s1_sh   <= (exp_in >= 8'd150) ? 5'(exp_in - 8'd150) : 5'(8'd150 - exp_in);
		end
	end

	////////////////////////////////////////
	// stage 2, shift
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2_sign <= s1_sign;
			s2_sat  <= s1_sat;
			if (s1_zero) begin
				s2_mag <= '0;
			end else if (s1_left) begin
				s2_mag <= {8'd0, s1_mant} << s1_sh;
			end else begin
				s2_mag <= {8'd0, s1_mant} >> s1_sh;
			end
		end
	end

	////////////////////////////////////////
	// stage 3, sign
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (s2_valid) begin
			if (s2_sat) begin
				result <= s2_sign ? 32'h8000_0000 : 32'h7fff_ffff;
			end else begin
				result <= s2_sign ? -s2_mag : s2_mag;
			end
		end
	end

endmodule

`default_nettype wire

//--- int_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module int_alu (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue,
	input  core_pkg::op_t      op,
	input  logic [`WORD_W-1:0] a,
	input  logic [`WORD_W-1:0] b,
	output logic [`WORD_W-1:0] result
);
	import core_pkg::*;

	logic [`WORD_W-1:0] next_result;

	// add and sub wrap naturally at word width
	always_comb begin
		case (op)
			OP_ADD: begin
				next_result = a + b;
			end
			OP_SUB: begin
				next_result = a - b;
			end
			default: begin
				next_result = a;
			end
		endcase
	end

	// result sits on the bus one cycle after issue
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else if (issue) begin
			result <= next_result;
		end
	end

endmodule

`default_nettype wire

//--- cdb_issue.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module cdb_issue (
	input  logic               clk,
	input  logic               rst_n,
	input  core_pkg::inst_t    inst,
	input  logic               inst_valid,
	input  logic               ring_full,
	input  logic [`TAG_W-1:0]  alloc_tag,
	input  logic [`WORD_W-1:0] alu_result,
	input  logic [`WORD_W-1:0] ftoi_result,
	output logic               inst_ready,
	output logic               alloc,
	output logic               alu_issue,
	output logic               ftoi_issue,
	output core_pkg::cdb_t     cdb
);
	import core_pkg::*;

	////////////////////////////////////////
	// issue
	////////////////////////////////////////

	logic is_ftoi;
	logic accept;

	// rsv[0] owns the bus this cycle, rsv[FTOI_LAT-1] is the far end
	rsv_t rsv [`FTOI_LAT-1:0];

	assign is_ftoi = inst.op == OP_FTOI;

	// alu result would land on a slot already held by an older ftoi
	assign inst_ready = !ring_full && !(!is_ftoi && rsv[`ALU_LAT].valid);

	assign accept     = inst_valid && inst_ready;
	assign alloc      = accept;
	assign alu_issue  = accept && !is_ftoi;
	assign ftoi_issue = accept && is_ftoi;

	////////////////////////////////////////
	// reservation chain
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int k = 0; k < `FTOI_LAT-1; k++) begin
			rsv[k] <= rsv[k+1];
		end
		rsv[`FTOI_LAT-1].valid <= ftoi_issue;
		rsv[`FTOI_LAT-1].tag   <= alloc_tag;
		rsv[`FTOI_LAT-1].unit  <= UNIT_FTOI;
		// alu joins closer to the bus
		if (alu_issue) begin
			rsv[`ALU_LAT-1].valid <= 1'b1;
			rsv[`ALU_LAT-1].tag   <= alloc_tag;
			rsv[`ALU_LAT-1].unit  <= UNIT_ALU;
		end
		if (!rst_n) begin
			for (int k = 0; k < `FTOI_LAT; k++) begin
				rsv[k].valid <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// result bus
	////////////////////////////////////////

	always_comb begin
		cdb.valid = rsv[0].valid;
		cdb.tag   = rsv[0].tag;
		cdb.data  = (rsv[0].unit == UNIT_FTOI) ? ftoi_result : alu_result;
	end

endmodule

`default_nettype wire

//--- core_pkg.sv
`default_nettype none
`include "core_defines.svh"

package core_pkg;

	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_MOV,
		OP_FTOI
	} op_t;

	// source of the word on the result bus
	typedef enum logic {
		UNIT_ALU,
		UNIT_FTOI
	} unit_t;

	// mov copies a, ftoi converts a
	typedef struct packed {
		op_t                op;
		logic [`WORD_W-1:0] a;
		logic [`WORD_W-1:0] b;
	} inst_t;

	typedef struct packed {
		logic               valid;
		logic [`TAG_W-1:0]  tag;
		logic [`WORD_W-1:0] data;
	} cdb_t;

	// one slot of the bus reservation chain
	typedef struct packed {
		logic              valid;
		logic [`TAG_W-1:0] tag;
		unit_t             unit;
	} rsv_t;

endpackage

`default_nettype wire

//--- core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

`define WORD_W 32

// commit ring sizing, tag indexes the ring
`define RING_DEPTH 8
`define TAG_W 3

////////////////////////////////////////
// issue to bus latencies in cycles
////////////////////////////////////////

`define ALU_LAT 1
`define FTOI_LAT 3

`endif
